// File: compile.f
verilog/riscv_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/mem_port.sv
verilog/control_unit.sv
verilog/datapath.sv
verilog/riscv_core.sv
verification/riscv_core_assertions.sv
verification/riscv_core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = riscv_core_tb
FILELIST = compile.f
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: verification/riscv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb;

    typedef struct packed {
        riscv_pkg::word_t addr;
        riscv_pkg::word_t data;
    } store_t;

    localparam int PROGRAM_LEN = 52;
    localparam int NUM_STORES = 21;
    // instructions on the taken path, up to the first fetch of the final jump.
    localparam int EXECUTED = 45;
    localparam int CYCLE_LIMIT = EXECUTED * (5 + 2 * 6) * 2;
    localparam riscv_pkg::word_t END_ADDR = 32'h0000_00CC;
    localparam int OPCODE_IMM = 7'b0010011;
    localparam int OPCODE_LOAD = 7'b0000011;
    localparam int OPCODE_JALR = 7'b1100111;
    localparam int OPCODE_LUI = 7'b0110111;
    localparam int OPCODE_AUIPC = 7'b0010111;

    logic clk;
    logic reset;
    logic ack;
    logic req;
    riscv_pkg::word_t rdata;
    riscv_pkg::mem_bus_t bus;

    riscv_pkg::word_t mem [0:63];
    riscv_pkg::word_t program_words [0:PROGRAM_LEN-1];
    store_t expected_stores [0:NUM_STORES-1];
    int store_count = 0;
    logic end_reached = 1'b0;
    integer seed;

    riscv_core DUT (
        .clk(clk),
        .reset(reset),
        .ack(ack),
        .rdata(rdata),
        .req(req),
        .bus(bus)
    );

    bind riscv_core riscv_core_assertions u_assertions (
        .clk(clk),
        .reset(reset),
        .req(req),
        .ack(ack),
        .bus(bus)
    );

    function automatic riscv_pkg::word_t r_type(input int funct7, input int rs2, input int rs1,
                                                input int funct3, input int rd);
        return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic riscv_pkg::word_t i_type(input int imm, input int rs1, input int funct3,
                                                input int rd, input int opcode);
        return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], opcode[6:0]};
    endfunction

    function automatic riscv_pkg::word_t s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic riscv_pkg::word_t b_type(input int imm, input int rs2, input int rs1);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic riscv_pkg::word_t u_type(input int imm, input int rd, input int opcode);
        return {imm[19:0], rd[4:0], opcode[6:0]};
    endfunction

    function automatic riscv_pkg::word_t j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic fail_and_stop();
        $display("Test failures found");
        $fatal(1, "simulation stopped after the first failure");
    endtask

    task automatic check_value(input string what, input riscv_pkg::word_t actual,
                               input riscv_pkg::word_t expected);
        if (actual !== expected) begin
            $display("error: %0t: %s is %h, expected %h", $time, what, actual, expected);
            fail_and_stop();
        end
    endtask

    // x1 = 7, x2 = -3, x3 = 0xf0f0f000; stores use x0 as base into the data words at 0x80.
    task automatic build_program();
        int i;
        program_words[0] = i_type(7, 0, 0, 1, OPCODE_IMM);
        program_words[1] = i_type(-3, 0, 0, 2, OPCODE_IMM);
        program_words[2] = u_type(32'hF0F0F, 3, OPCODE_LUI);
        program_words[3] = s_type(128, 2, 0);
        program_words[4] = s_type(128, 3, 0);
        program_words[5] = r_type(0, 2, 1, 0, 4);
        program_words[6] = s_type(128, 4, 0);
        program_words[7] = r_type(32, 2, 1, 0, 5);
        program_words[8] = s_type(128, 5, 0);
        program_words[9] = r_type(0, 2, 1, 7, 6);
        program_words[10] = s_type(128, 6, 0);
        program_words[11] = r_type(0, 1, 3, 6, 7);
        program_words[12] = s_type(128, 7, 0);
        program_words[13] = r_type(0, 2, 3, 4, 8);
        program_words[14] = s_type(128, 8, 0);
        program_words[15] = r_type(0, 1, 2, 2, 9);
        program_words[16] = s_type(128, 9, 0);
        program_words[17] = r_type(0, 5, 1, 1, 11);
        program_words[18] = s_type(128, 11, 0);
        program_words[19] = r_type(0, 1, 3, 5, 12);
        program_words[20] = s_type(128, 12, 0);
        program_words[21] = i_type(-2, 7, 7, 13, OPCODE_IMM);
        program_words[22] = s_type(128, 13, 0);
        program_words[23] = i_type(-256, 1, 6, 14, OPCODE_IMM);
        program_words[24] = s_type(128, 14, 0);
        program_words[25] = i_type(-1, 1, 4, 15, OPCODE_IMM);
        program_words[26] = s_type(128, 15, 0);
        program_words[27] = i_type(-2, 2, 2, 16, OPCODE_IMM);
        program_words[28] = s_type(128, 16, 0);
        program_words[29] = u_type(1, 17, OPCODE_AUIPC);
        program_words[30] = s_type(128, 17, 0);
        // the jump at 0x7c skips the zeroed data words and lands at 0x90.
        program_words[31] = j_type(20, 18);
        for (i = 32; i < 36; i++) begin
            program_words[i] = '0;
        end
        program_words[36] = s_type(128, 18, 0);
        program_words[37] = s_type(132, 8, 0);
        program_words[38] = i_type(132, 0, 2, 19, OPCODE_LOAD);
        program_words[39] = i_type(3, 19, 0, 19, OPCODE_IMM);
        program_words[40] = s_type(136, 19, 0);
        // words 42, 46 and 47 hold marker stores that must never execute.
        program_words[41] = b_type(8, 1, 1);
        program_words[42] = s_type(140, 2, 0);
        program_words[43] = b_type(8, 2, 1);
        program_words[44] = s_type(140, 1, 0);
        program_words[45] = i_type(193, 0, 0, 20, OPCODE_JALR);
        program_words[46] = s_type(140, 2, 0);
        program_words[47] = s_type(140, 2, 0);
        program_words[48] = s_type(128, 20, 0);
        program_words[49] = i_type(5, 0, 0, 0, OPCODE_IMM);
        program_words[50] = s_type(128, 0, 0);
        program_words[51] = j_type(0, 0);
    endtask

    task automatic build_expected_stores();
        expected_stores[0] = {32'h0000_0080, 32'hFFFF_FFFD};
        expected_stores[1] = {32'h0000_0080, 32'hF0F0_F000};
        expected_stores[2] = {32'h0000_0080, 32'h0000_0004};
        expected_stores[3] = {32'h0000_0080, 32'h0000_000A};
        expected_stores[4] = {32'h0000_0080, 32'h0000_0005};
        expected_stores[5] = {32'h0000_0080, 32'hF0F0_F007};
        expected_stores[6] = {32'h0000_0080, 32'h0F0F_0FFD};
        expected_stores[7] = {32'h0000_0080, 32'h0000_0001};
        expected_stores[8] = {32'h0000_0080, 32'h0000_1C00};
        // srl is logical, so the set sign bit of x3 does not spread.
        expected_stores[9] = {32'h0000_0080, 32'h01E1_E1E0};
        expected_stores[10] = {32'h0000_0080, 32'hF0F0_F006};
        expected_stores[11] = {32'h0000_0080, 32'hFFFF_FF07};
        expected_stores[12] = {32'h0000_0080, 32'hFFFF_FFF8};
        expected_stores[13] = {32'h0000_0080, 32'h0000_0001};
        expected_stores[14] = {32'h0000_0080, 32'h0000_1074};
        expected_stores[15] = {32'h0000_0080, 32'h0000_0080};
        expected_stores[16] = {32'h0000_0084, 32'h0F0F_0FFD};
        expected_stores[17] = {32'h0000_0088, 32'h0F0F_1000};
        expected_stores[18] = {32'h0000_008C, 32'h0000_0007};
        expected_stores[19] = {32'h0000_0080, 32'h0000_00B8};
        expected_stores[20] = {32'h0000_0080, 32'h0000_0000};
    endtask

    task automatic serve_request();
        if (bus.we) begin
            if (store_count >= NUM_STORES) begin
                $display("unexpected store of %h to address %h after the last expected store",
                         bus.wdata, bus.addr);
                fail_and_stop();
            end else begin
                check_value($sformatf("store %0d address", store_count), bus.addr,
                            expected_stores[store_count].addr);
                check_value($sformatf("store %0d data", store_count), bus.wdata,
                            expected_stores[store_count].data);
                mem[bus.addr[7:2]] = bus.wdata;
                store_count++;
            end
        end else begin
            rdata = mem[bus.addr[7:2]];
            if (bus.addr == END_ADDR) begin
                end_reached = 1'b1;
            end
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ack follows req after 0 to 3 cycles and falls once req is low.
    initial begin : memory_model
        int delay;
        ack = 1'b0;
        rdata = '0;
        seed = 67;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && req) begin
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                serve_request();
                ack = 1'b1;
                while (req) begin
                    @(posedge clk);
                    #1;
                end
                ack = 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLE_LIMIT) begin
                $display("timeout: the program did not reach its final jump within %0d cycles",
                         CYCLE_LIMIT);
                fail_and_stop();
            end
        end
    end

    initial begin : main_sequence
        int i;
        reset = 1'b1;
        build_program();
        build_expected_stores();
        for (i = 0; i < 64; i++) begin
            if (i < PROGRAM_LEN) begin
                mem[i] = program_words[i];
            end else begin
                mem[i] = 32'hBAD0_0000 | (i << 2);
            end
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        while (!end_reached) begin
            @(posedge clk);
        end
        if (store_count == NUM_STORES) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("the program ended after %0d of %0d expected stores",
                     store_count, NUM_STORES);
            fail_and_stop();
        end
    end

endmodule

`default_nettype wire

// File: verification/riscv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_assertions (
    input logic clk,
    input logic reset,
    input logic req,
    input logic ack,
    input riscv_pkg::mem_bus_t bus
);

    // a request is held until the memory has answered it.
    req_held: assert property (@(posedge clk) disable iff (reset)
        req && !ack |=> req)
        else $error("req dropped before ack");

    bus_stable: assert property (@(posedge clk) disable iff (reset)
        req && !ack |=> $stable(bus))
        else $error("addr, wdata or we changed while waiting for ack");

    addr_aligned: assert property (@(posedge clk) disable iff (reset)
        req |-> bus.addr[1:0] == 2'b00)
        else $error("misaligned bus address %h", bus.addr);

    req_low_after_reset: assert property (@(posedge clk)
        reset |=> !req)
        else $error("req high in the cycle after reset");

endmodule

`default_nettype wire

// File: verilog/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core (
    input logic clk,
    input logic reset,
    input logic ack,
    input riscv_pkg::word_t rdata,
    output logic req,
    output riscv_pkg::mem_bus_t bus
);

    riscv_pkg::ctrl_t ctrl;
    riscv_pkg::opcode_t opcode;
    riscv_pkg::word_t mem_data;
    logic zero;
    logic mem_done;

    control_unit u_control_unit (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .zero(zero),
        .mem_done(mem_done),
        .ctrl(ctrl)
    );

    datapath u_datapath (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrl),
        .mem_done(mem_done),
        .mem_data(mem_data),
        .opcode(opcode),
        .zero(zero),
        .bus(bus)
    );

    mem_port u_mem_port (
        .clk(clk),
        .reset(reset),
        .access(ctrl.mem_access),
        .ack(ack),
        .rdata(rdata),
        .req(req),
        .done(mem_done),
        .data(mem_data)
    );

endmodule

`default_nettype wire

// File: verilog/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input logic clk,
    input logic reset,
    input riscv_pkg::ctrl_t ctrl,
    input logic mem_done,
    input riscv_pkg::word_t mem_data,
    output riscv_pkg::opcode_t opcode,
    output logic zero,
    output riscv_pkg::mem_bus_t bus
);

    riscv_pkg::word_t pc;
    riscv_pkg::word_t old_pc;
    riscv_pkg::word_t ir;
    riscv_pkg::word_t mdr;
    riscv_pkg::word_t a_reg;
    riscv_pkg::word_t b_reg;
    riscv_pkg::word_t alu_out;
    riscv_pkg::word_t rd1;
    riscv_pkg::word_t rd2;
    riscv_pkg::word_t imm;
    riscv_pkg::word_t src_a;
    riscv_pkg::word_t src_b;
    riscv_pkg::word_t alu_result;
    riscv_pkg::word_t pc_next;
    logic stall;

    assign stall = ctrl.mem_access && !mem_done;
    assign opcode = ir[6:0];

    always_comb begin
        case (ir[6:0])
            riscv_pkg::OP_SW: imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            riscv_pkg::OP_BEQ: imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            riscv_pkg::OP_JAL: imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            riscv_pkg::OP_AUIPC: imm = {ir[31:12], 12'd0};
            riscv_pkg::OP_LUI: imm = {ir[31:12], 12'd0};
            default: imm = {{20{ir[31]}}, ir[31:20]};
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_a)
            riscv_pkg::SRC_A_PC: src_a = pc;
            riscv_pkg::SRC_A_REG: src_a = a_reg;
            riscv_pkg::SRC_A_OLD_PC: src_a = old_pc;
            default: src_a = '0;
        endcase
        case (ctrl.alu_src_b)
            riscv_pkg::SRC_B_REG: src_b = b_reg;
            riscv_pkg::SRC_B_FOUR: src_b = 32'd4;
            default: src_b = imm;
        endcase
    end

    alu u_alu (
        .alu_class(ctrl.alu_class),
        .is_immediate(ctrl.is_immediate),
        .funct3(ir[14:12]),
        .funct7_5(ir[30]),
        .a(src_a),
        .b(src_b),
        .result(alu_result),
        .zero(zero)
    );

    register_file u_register_file (
        .clk(clk),
        .rs1(ir[19:15]),
        .rs2(ir[24:20]),
        .rd(ir[11:7]),
        .write_en(ctrl.reg_write),
        .write_data(ctrl.memory_to_reg ? mdr : alu_out),
        .rd1(rd1),
        .rd2(rd2)
    );

    // jump targets come from ALU-out; bit 0 is cleared as JALR requires.
    assign pc_next = ctrl.pc_source ? {alu_out[31:1], 1'b0} : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (ctrl.pc_write) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_done && ctrl.ir_write) begin
            ir <= mem_data;
            old_pc <= pc;
        end
        if (mem_done && !ctrl.ir_write) begin
            mdr <= mem_data;
        end
        if (!stall) begin
            a_reg <= rd1;
            b_reg <= rd2;
            alu_out <= alu_result;
        end
    end

    assign bus.addr = ctrl.lord ? alu_out : pc;
    assign bus.wdata = b_reg;
    assign bus.we = ctrl.mem_write;

endmodule

`default_nettype wire

// File: verilog/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input logic clk,
    input logic reset,
    input riscv_pkg::opcode_t opcode,
    input logic zero,
    input logic mem_done,
    output riscv_pkg::ctrl_t ctrl
);

    riscv_pkg::cpu_state_t state;
    riscv_pkg::cpu_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= riscv_pkg::FETCH;
        end else begin
            state <= next_state;
        end
    end

    // the three memory states hold until the bus handshake has finished.
    always_comb begin
        next_state = riscv_pkg::FETCH;
        case (state)
            riscv_pkg::FETCH: begin
                next_state = mem_done ? riscv_pkg::DECODE : riscv_pkg::FETCH;
            end
            riscv_pkg::DECODE: begin
                case (opcode)
                    riscv_pkg::OP_LW: next_state = riscv_pkg::MEMADR;
                    riscv_pkg::OP_SW: next_state = riscv_pkg::MEMADR;
                    riscv_pkg::OP_RTYPE: next_state = riscv_pkg::EXECUTER;
                    riscv_pkg::OP_ITYPE: next_state = riscv_pkg::EXECUTEI;
                    riscv_pkg::OP_JAL: next_state = riscv_pkg::JAL;
                    riscv_pkg::OP_BEQ: next_state = riscv_pkg::BEQ;
                    riscv_pkg::OP_JALR: next_state = riscv_pkg::JALR_PC;
                    riscv_pkg::OP_AUIPC: next_state = riscv_pkg::AUIPC;
                    riscv_pkg::OP_LUI: next_state = riscv_pkg::LUI;
                    default: next_state = riscv_pkg::FETCH;
                endcase
            end
            riscv_pkg::MEMADR: begin
                if (opcode == riscv_pkg::OP_LW) begin
                    next_state = riscv_pkg::MEMREAD;
                end else begin
                    next_state = riscv_pkg::MEMWRITE;
                end
            end
            riscv_pkg::MEMREAD: begin
                next_state = mem_done ? riscv_pkg::MEMWB : riscv_pkg::MEMREAD;
            end
            riscv_pkg::MEMWRITE: begin
                next_state = mem_done ? riscv_pkg::FETCH : riscv_pkg::MEMWRITE;
            end
            riscv_pkg::EXECUTER: next_state = riscv_pkg::ALUWB;
            riscv_pkg::EXECUTEI: next_state = riscv_pkg::ALUWB;
            riscv_pkg::JAL: next_state = riscv_pkg::ALUWB;
            riscv_pkg::JALR_PC: next_state = riscv_pkg::JALR;
            riscv_pkg::JALR: next_state = riscv_pkg::ALUWB;
            riscv_pkg::AUIPC: next_state = riscv_pkg::ALUWB;
            riscv_pkg::LUI: next_state = riscv_pkg::ALUWB;
            default: next_state = riscv_pkg::FETCH;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.alu_class = riscv_pkg::ALU_ADD;
        ctrl.alu_src_a = riscv_pkg::SRC_A_PC;
        ctrl.alu_src_b = riscv_pkg::SRC_B_REG;
        case (state)
            riscv_pkg::FETCH: begin
                ctrl.mem_access = 1'b1;
                ctrl.ir_write = 1'b1;
                ctrl.alu_src_b = riscv_pkg::SRC_B_FOUR;
                // the PC moves on only when the instruction word has arrived.
                ctrl.pc_write = mem_done;
            end
            riscv_pkg::DECODE: begin
                ctrl.alu_src_a = riscv_pkg::SRC_A_OLD_PC;
                ctrl.alu_src_b = riscv_pkg::SRC_B_IMM;
            end
            riscv_pkg::MEMADR: begin
                ctrl.alu_src_a = riscv_pkg::SRC_A_REG;
                ctrl.alu_src_b = riscv_pkg::SRC_B_IMM;
            end
            riscv_pkg::MEMREAD: begin
                ctrl.mem_access = 1'b1;
                ctrl.lord = 1'b1;
            end
            riscv_pkg::MEMWB: begin
                ctrl.reg_write = 1'b1;
                ctrl.memory_to_reg = 1'b1;
            end
            riscv_pkg::MEMWRITE: begin
                ctrl.mem_access = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.lord = 1'b1;
            end
            riscv_pkg::EXECUTER: begin
                ctrl.alu_src_a = riscv_pkg::SRC_A_REG;
                ctrl.alu_class = riscv_pkg::ALU_FUNCT;
            end
            riscv_pkg::EXECUTEI: begin
                ctrl.alu_src_a = riscv_pkg::SRC_A_REG;
                ctrl.alu_src_b = riscv_pkg::SRC_B_IMM;
                ctrl.alu_class = riscv_pkg::ALU_FUNCT;
                ctrl.is_immediate = 1'b1;
            end
            riscv_pkg::ALUWB: begin
                ctrl.reg_write = 1'b1;
            end
            riscv_pkg::JAL, riscv_pkg::JALR: begin
                // target was computed one state earlier; the ALU now forms the link.
                ctrl.alu_src_a = riscv_pkg::SRC_A_OLD_PC;
                ctrl.alu_src_b = riscv_pkg::SRC_B_FOUR;
                ctrl.pc_write = 1'b1;
                ctrl.pc_source = 1'b1;
            end
            riscv_pkg::BEQ: begin
                ctrl.alu_src_a = riscv_pkg::SRC_A_REG;
                ctrl.alu_class = riscv_pkg::ALU_SUB;
                ctrl.pc_write_cond = 1'b1;
                ctrl.pc_source = 1'b1;
            end
            riscv_pkg::JALR_PC: begin
                ctrl.alu_src_a = riscv_pkg::SRC_A_REG;
                ctrl.alu_src_b = riscv_pkg::SRC_B_IMM;
            end
            riscv_pkg::AUIPC: begin
                ctrl.alu_src_a = riscv_pkg::SRC_A_OLD_PC;
                ctrl.alu_src_b = riscv_pkg::SRC_B_IMM;
            end
            riscv_pkg::LUI: begin
                ctrl.alu_src_a = riscv_pkg::SRC_A_ZERO;
                ctrl.alu_src_b = riscv_pkg::SRC_B_IMM;
            end
            default: begin
                ctrl.alu_class = riscv_pkg::ALU_ADD;
            end
        endcase
        // a taken branch is folded into the PC write enable here.
        if (ctrl.pc_write_cond && zero) begin
            ctrl.pc_write = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input logic clk,
    input logic reset,
    input logic access,
    input logic ack,
    input riscv_pkg::word_t rdata,
    output logic req,
    output logic done,
    output riscv_pkg::word_t data
);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_REQ,
        PH_REL,
        PH_DONE
    } phase_t;

    phase_t phase;

    // done is one idle cycle, so a held access does not start a second transfer.
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PH_IDLE;
        end else begin
            case (phase)
                PH_IDLE: phase <= access ? PH_REQ : PH_IDLE;
                PH_REQ: phase <= ack ? PH_REL : PH_REQ;
                PH_REL: phase <= ack ? PH_REL : PH_DONE;
                default: phase <= PH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == PH_REQ && ack) begin
            data <= rdata;
        end
    end

    assign req = (phase == PH_REQ);
    assign done = (phase == PH_DONE);

endmodule

`default_nettype wire

// File: verilog/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input logic clk,
    input riscv_pkg::reg_addr_t rs1,
    input riscv_pkg::reg_addr_t rs2,
    input riscv_pkg::reg_addr_t rd,
    input logic write_en,
    input riscv_pkg::word_t write_data,
    output riscv_pkg::word_t rd1,
    output riscv_pkg::word_t rd2
);

    riscv_pkg::word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (write_en && rd != 5'd0) begin
            regs[rd] <= write_data;
        end
    end

    // x0 never holds a written value, so it is read as zero.
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input riscv_pkg::alu_class_t alu_class,
    input logic is_immediate,
    input logic [2:0] funct3,
    input logic funct7_5,
    input riscv_pkg::word_t a,
    input riscv_pkg::word_t b,
    output riscv_pkg::word_t result,
    output logic zero
);

    riscv_pkg::word_t sum;
    riscv_pkg::word_t diff;
    riscv_pkg::word_t funct_result;

    assign sum = a + b;
    assign diff = a - b;

    // immediate forms have no SUB, and their bit 30 belongs to the immediate.
    always_comb begin
        case (funct3)
            3'b000: funct_result = (funct7_5 && !is_immediate) ? diff : sum;
            3'b001: funct_result = a << b[4:0];
            3'b010: funct_result = {31'd0, $signed(a) < $signed(b)};
            3'b100: funct_result = a ^ b;
            3'b101: funct_result = a >> b[4:0];
            3'b110: funct_result = a | b;
            3'b111: funct_result = a & b;
            default: funct_result = sum;
        endcase
    end

    always_comb begin
        case (alu_class)
            riscv_pkg::ALU_ADD: result = sum;
            riscv_pkg::ALU_SUB: result = diff;
            riscv_pkg::ALU_FUNCT: result = funct_result;
            default: result = sum;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: verilog/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [1:0] alu_class_t;
    typedef logic [1:0] src_a_sel_t;
    typedef logic [1:0] src_b_sel_t;

    localparam opcode_t OP_LW = 7'b0000011;
    localparam opcode_t OP_SW = 7'b0100011;
    localparam opcode_t OP_RTYPE = 7'b0110011;
    localparam opcode_t OP_ITYPE = 7'b0010011;
    localparam opcode_t OP_JAL = 7'b1101111;
    localparam opcode_t OP_BEQ = 7'b1100011;
    localparam opcode_t OP_JALR = 7'b1100111;
    localparam opcode_t OP_AUIPC = 7'b0010111;
    localparam opcode_t OP_LUI = 7'b0110111;

    // ALU_FUNCT hands the choice of operation to funct3 and funct7.
    localparam alu_class_t ALU_ADD = 2'd0;
    localparam alu_class_t ALU_SUB = 2'd1;
    localparam alu_class_t ALU_FUNCT = 2'd2;

    localparam src_a_sel_t SRC_A_PC = 2'd0;
    localparam src_a_sel_t SRC_A_REG = 2'd1;
    localparam src_a_sel_t SRC_A_OLD_PC = 2'd2;
    localparam src_a_sel_t SRC_A_ZERO = 2'd3;

    localparam src_b_sel_t SRC_B_REG = 2'd0;
    localparam src_b_sel_t SRC_B_FOUR = 2'd1;
    localparam src_b_sel_t SRC_B_IMM = 2'd2;

    typedef struct packed {
        logic pc_write;
        logic pc_write_cond;
        logic lord;
        logic mem_access;
        logic mem_write;
        logic memory_to_reg;
        logic ir_write;
        logic pc_source;
        logic is_immediate;
        alu_class_t alu_class;
        src_a_sel_t alu_src_a;
        src_b_sel_t alu_src_b;
        logic reg_write;
    } ctrl_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic we;
    } mem_bus_t;

    typedef enum logic [3:0] {
        FETCH = 4'd0,
        DECODE = 4'd1,
        MEMADR = 4'd2,
        MEMREAD = 4'd3,
        MEMWB = 4'd4,
        MEMWRITE = 4'd5,
        EXECUTER = 4'd6,
        ALUWB = 4'd7,
        EXECUTEI = 4'd8,
        JAL = 4'd9,
        BEQ = 4'd10,
        JALR = 4'd11,
        AUIPC = 4'd12,
        LUI = 4'd13,
        JALR_PC = 4'd14
    } cpu_state_t;

endpackage

`default_nettype wire
